// ==== design/decode_pkg.sv ====
// decode stage package: major opcodes, exception causes, formats, field widths
package decode_pkg;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    LOAD      = 5'b00000,
    LOADFP    = 5'b00001,
    CUSTOM0   = 5'b00010,
    MISCMEM   = 5'b00011,
    OPIMM     = 5'b00100,
    AUIPC     = 5'b00101,
    OPIMM32   = 5'b00110,
    B48_0     = 5'b00111,
    STORE     = 5'b01000,
    STOREFP   = 5'b01001,
    CUSTOM1   = 5'b01010,
    AMO       = 5'b01011,
    OP        = 5'b01100,
    LUI       = 5'b01101,
    OP32      = 5'b01110,
    B64       = 5'b01111,
    MADD      = 5'b10000,
    MSUB      = 5'b10001,
    NMSUB     = 5'b10010,
    NMADD     = 5'b10011,
    OPFP      = 5'b10100,
    RESERVED0 = 5'b10101,
    CUSTOM2   = 5'b10110,
    B48_1     = 5'b10111,
    BRANCH    = 5'b11000,
    JALR      = 5'b11001,
    RESERVED1 = 5'b11010,
    JAL       = 5'b11011,
    SYSTEM    = 5'b11100,
    RESERVED2 = 5'b11101,
    CUSTOM3   = 5'b11110,
    B80       = 5'b11111
  } opcode_e;

  // exception cause reported to the ROB
  typedef enum logic [1:0] {
    ECAUSE_IALIGN   = 2'd0,
    ECAUSE_IFAULT   = 2'd1,
    ECAUSE_IILLEGAL = 2'd2
  } ecause_e;

  // instruction format, FMT_INV for anything unimplemented
  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_INV
  } fmt_e;

  localparam int ROBID_W = 7;
  localparam int BPTAG_W = 16;
  localparam int RSOP_W  = 5;
  localparam int RETOP_W = 7;

endpackage

// ==== design/fetch_de_if.sv ====
// fetch_de_if: one fetched instruction from the fetch queue to the decoder
`timescale 1ns/1ps

interface fetch_de_if;
  import decode_pkg::*;

  logic               valid;
  logic               error;
  logic [31:1]        addr;
  logic [31:0]        insn;
  logic [BPTAG_W-1:0] bptag;
  logic               bptaken;
  // transfer on valid && !stall, source holds while stalled
  logic               stall;

  modport source (
    output valid,
    output error,
    output addr,
    output insn,
    output bptag,
    output bptaken,
    input  stall
  );

  modport sink (
    input  valid,
    input  error,
    input  addr,
    input  insn,
    input  bptag,
    input  bptaken,
    output stall
  );

endinterface

// ==== design/fetch_queue.sv ====
// fetch_queue: circular FIFO of fetched instructions in front of the decoder
`timescale 1ns/1ps

module fetch_queue #(
  parameter int FQ_DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         flush_i,
  input  logic                         fetch_valid_i,
  input  logic                         fetch_error_i,
  input  logic                         fetch_bptaken_i,
  input  logic [31:1]                  fetch_addr_i,
  input  logic [31:0]                  fetch_insn_i,
  input  logic [decode_pkg::BPTAG_W-1:0] fetch_bptag_i,
  output logic                         fetch_ready_o,
  fetch_de_if.source                   de
);
  import decode_pkg::*;

  localparam int PTR_W = $clog2(FQ_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic               err_mem    [FQ_DEPTH];
  logic [31:1]        addr_mem   [FQ_DEPTH];
  logic [31:0]        insn_mem   [FQ_DEPTH];
  logic [BPTAG_W-1:0] bptag_mem  [FQ_DEPTH];
  logic               taken_mem  [FQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, push, pop;

  assign full          = (count_q == CNT_W'(FQ_DEPTH));
  assign fetch_ready_o = ~full;
  // push while full is dropped
  assign push          = fetch_valid_i & ~full;
  assign pop           = de.valid & ~de.stall;

  // head entry
  assign de.valid   = (count_q != '0);
  assign de.error   = err_mem[rd_ptr_q];
  assign de.addr    = addr_mem[rd_ptr_q];
  assign de.insn    = insn_mem[rd_ptr_q];
  assign de.bptag   = bptag_mem[rd_ptr_q];
  assign de.bptaken = taken_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      err_mem[wr_ptr_q]   <= fetch_error_i;
      addr_mem[wr_ptr_q]  <= fetch_addr_i;
      insn_mem[wr_ptr_q]  <= fetch_insn_i;
      bptag_mem[wr_ptr_q] <= fetch_bptag_i;
      taken_mem[wr_ptr_q] <= fetch_bptaken_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // occupancy bounded and in step with the pointers
  fq_count_bound: assert property (@(posedge clk) disable iff (rst_i)
    count_q <= CNT_W'(FQ_DEPTH) && PTR_W'(count_q) == PTR_W'(wr_ptr_q - rd_ptr_q));

endmodule

// ==== design/decode.sv ====
// decode: instruction register, format decode, immediates, branch target, rsop/retop
`timescale 1ns/1ps

module decode (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         flush_i,
  fetch_de_if.sink                     de,
  input  logic                         rob_full_i,
  input  logic [decode_pkg::ROBID_W-1:0] rob_robid_i,
  input  logic                         rename_stall_i,

  // toward the ROB
  output logic                         rob_valid_o,
  output logic                         error_o,
  output decode_pkg::ecause_e          ecause_o,
  output logic [decode_pkg::RETOP_W-1:0] retop_o,
  output logic [decode_pkg::BPTAG_W-1:0] bptag_o,
  output logic                         bptaken_o,

  // shared by ROB and rename
  output logic [5:0]                   rd_o,
  output logic [31:2]                  addr_o,
  output logic [31:2]                  target_o,
  output logic                         forward_o,

  // toward rename
  output logic                         rename_valid_o,
  output logic [decode_pkg::RSOP_W-1:0] rsop_o,
  output logic [decode_pkg::ROBID_W-1:0] robid_o,
  output logic                         uses_rs1_o,
  output logic                         uses_rs2_o,
  output logic                         uses_imm_o,
  output logic                         uses_memory_o,
  output logic                         uses_pc_o,
  output logic                         csr_access_o,
  output logic                         inhibit_o,
  output logic [4:0]                   rs1_o,
  output logic [4:0]                   rs2_o,
  output logic [31:0]                  imm_o
);
  import decode_pkg::*;

  logic               valid_q;
  logic               error_q;
  logic [31:1]        addr_q;
  logic [31:0]        insn_q;
  logic [BPTAG_W-1:0] bptag_q;
  logic               bptaken_q;

  logic       decode_stall;
  opcode_e    opcode;
  fmt_e       fmt;
  logic       fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_inv;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic       insn_load, insn_jalr, insn_auipc, insn_csr;
  logic       uses_rd;
  logic       altop;
  logic [2:0] brop;
  logic       target_ntaken;
  logic [31:0] imm;
  logic [31:1] target;
  logic [RSOP_W-1:0] rsop;

  assign decode_stall = rob_full_i | rename_stall_i;
  assign de.stall     = decode_stall;

  // held valid, the only control state here
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (!decode_stall) begin
      valid_q <= de.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!decode_stall && de.valid) begin
      error_q   <= de.error;
      addr_q    <= de.addr;
      insn_q    <= de.insn;
      bptag_q   <= de.bptag;
      bptaken_q <= de.bptaken;
    end
  end

  assign opcode = opcode_e'(insn_q[6:2]);
  assign funct3 = insn_q[14:12];
  assign rd     = insn_q[11:7];

  // format decoder, compressed words are invalid
  always_comb begin
    fmt = FMT_INV;
    if (insn_q[1:0] == 2'b11) begin
      case (opcode)
        OP:                                 fmt = FMT_R;
        OPIMM, LOAD, JALR, MISCMEM, SYSTEM: fmt = FMT_I;
        STORE:                              fmt = FMT_S;
        BRANCH:                             fmt = FMT_B;
        LUI, AUIPC:                         fmt = FMT_U;
        JAL:                                fmt = FMT_J;
        default:                            fmt = FMT_INV;
      endcase
    end
  end

  assign fmt_r   = (fmt == FMT_R);
  assign fmt_i   = (fmt == FMT_I);
  assign fmt_s   = (fmt == FMT_S);
  assign fmt_b   = (fmt == FMT_B);
  assign fmt_u   = (fmt == FMT_U);
  assign fmt_j   = (fmt == FMT_J);
  assign fmt_inv = (fmt == FMT_INV);

  assign insn_load  = (opcode == LOAD);
  assign insn_jalr  = (opcode == JALR);
  assign insn_auipc = (opcode == AUIPC);
  // csrrw/s/c and immediate forms, not ecall/ebreak
  assign insn_csr   = (opcode == SYSTEM) && (funct3[1:0] != 2'b00);

  assign uses_rd = (fmt_r | fmt_i | fmt_u | fmt_j) & (rd != 5'd0);

  // immediate generator
  always_comb begin
    case (fmt)
      FMT_I:   imm = {{20{insn_q[31]}}, insn_q[31:20]};
      FMT_S:   imm = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
      FMT_B:   imm = {{19{insn_q[31]}}, insn_q[31], insn_q[7], insn_q[30:25],
                      insn_q[11:8], 1'b0};
      FMT_U:   imm = {insn_q[31:12], 12'd0};
      FMT_J:   imm = {{11{insn_q[31]}}, insn_q[31], insn_q[19:12], insn_q[20],
                      insn_q[30:21], 1'b0};
      default: imm = 32'd0;
    endcase
  end

  // fall-through address when predicted taken or jalr, else pc-relative target
  assign target_ntaken = (fmt_b & bptaken_q) | insn_jalr;
  assign target = {addr_q[31:2], 1'b0} + (target_ntaken ? 31'd2 : imm[31:1]);

  // srai/srli and sub share funct3 with their plain forms
  assign altop = (fmt_r | (funct3 == 3'b101)) & insn_q[30];
  assign brop  = {~|funct3[2:1], funct3[2:1]};

  always_comb begin
    if (uses_memory_o) begin
      rsop = {1'b0, fmt_s, funct3};
    end else if (fmt_j || insn_jalr || fmt_u) begin
      rsop = '0;
    end else if (fmt_b) begin
      rsop = {2'b01, brop};
    end else begin
      rsop = {fmt_r & insn_q[25], altop, funct3};
    end
  end

  // ROB side
  assign rob_valid_o = valid_q & ~rename_stall_i & ~rob_full_i;
  assign error_o     = error_q | fmt_inv;
  assign ecause_o    = error_q ? (addr_q[1] ? ECAUSE_IALIGN : ECAUSE_IFAULT)
                               : ECAUSE_IILLEGAL;
  assign retop_o     = {fmt_b, funct3[0], insn_jalr, fmt_s, funct3};
  assign bptag_o     = bptag_q;
  assign bptaken_o   = bptaken_q;

  assign rd_o      = {~uses_rd, rd};
  assign addr_o    = addr_q[31:2];
  assign target_o  = target[31:2];
  assign forward_o = insn_jalr;

  // rename side
  assign rename_valid_o = valid_q & ~error_o & ~rob_full_i;
  assign rsop_o         = rsop;
  assign robid_o        = rob_robid_i;
  assign uses_rs1_o     = fmt_r | (fmt_i & (~insn_csr | ~funct3[2])) | fmt_s | fmt_b;
  assign uses_rs2_o     = fmt_r | fmt_s | fmt_b;
  assign uses_imm_o     = ~fmt_r & ~fmt_b;
  assign uses_memory_o  = insn_load | fmt_s;
  assign uses_pc_o      = fmt_j | insn_auipc;
  assign csr_access_o   = insn_csr;
  assign inhibit_o      = insn_jalr;
  assign rs1_o          = insn_q[19:15];
  assign rs2_o          = insn_q[24:20];
  // jal writes the link value pc+4
  assign imm_o          = fmt_j ? 32'd4 : imm;

  // queue head must stay put while the decoder stalls
  head_held_on_stall: assert property (@(posedge clk) disable iff (rst_i || flush_i)
    de.valid && de.stall |=> de.valid && $stable(de.insn) && $stable(de.addr));

endmodule

// ==== design/rob_tracker.sv ====
// rob_tracker: ROB id allocation, occupancy count and full flag
`timescale 1ns/1ps

module rob_tracker #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         flush_i,
  input  logic                         retire_i,
  input  logic                         rob_valid_i,
  output logic                         rob_full_o,
  output logic [decode_pkg::ROBID_W-1:0] robid_o
);
  import decode_pkg::*;

  localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

  logic [CNT_W-1:0]   count_q;
  logic [ROBID_W-1:0] robid_q;
  logic               dealloc;

  // retire on an empty ROB is ignored
  assign dealloc    = retire_i & (count_q != '0);
  assign rob_full_o = (count_q == CNT_W'(ROB_DEPTH));
  assign robid_o    = robid_q;

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      count_q <= '0;
    end else begin
      case ({rob_valid_i, dealloc})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // next id wraps at ROB_DEPTH
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      robid_q <= '0;
    end else if (rob_valid_i) begin
      if (robid_q == ROBID_W'(ROB_DEPTH - 1)) begin
        robid_q <= '0;
      end else begin
        robid_q <= robid_q + 1'b1;
      end
    end
  end

  // decoder must hold off while the ROB is full
  no_alloc_when_full: assert property (@(posedge clk) disable iff (rst_i)
    rob_valid_i |-> !rob_full_o);

endmodule

// ==== design/frontend_decode_top.sv ====
// frontend_decode_top: fetch queue, decoder and ROB tracker on plain ports
`timescale 1ns/1ps

module frontend_decode_top #(
  parameter int FQ_DEPTH  = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           flush_i,
  input  logic                           retire_i,
  input  logic                           rename_stall_i,
  input  logic                           fetch_valid_i,
  input  logic                           fetch_error_i,
  input  logic [31:1]                    fetch_addr_i,
  input  logic [31:0]                    fetch_insn_i,
  input  logic [decode_pkg::BPTAG_W-1:0] fetch_bptag_i,
  input  logic                           fetch_bptaken_i,
  output logic                           fetch_ready_o,
  output logic                           rob_full_o,
  output logic                           rob_valid_o,
  output logic                           error_o,
  output decode_pkg::ecause_e            ecause_o,
  output logic [decode_pkg::RETOP_W-1:0] retop_o,
  output logic [decode_pkg::BPTAG_W-1:0] bptag_o,
  output logic                           bptaken_o,
  output logic [5:0]                     rd_o,
  output logic [31:2]                    addr_o,
  output logic [31:2]                    target_o,
  output logic                           forward_o,
  output logic                           rename_valid_o,
  output logic [decode_pkg::RSOP_W-1:0]  rsop_o,
  output logic [decode_pkg::ROBID_W-1:0] robid_o,
  output logic                           uses_rs1_o,
  output logic                           uses_rs2_o,
  output logic                           uses_imm_o,
  output logic                           uses_memory_o,
  output logic                           uses_pc_o,
  output logic                           csr_access_o,
  output logic                           inhibit_o,
  output logic [4:0]                     rs1_o,
  output logic [4:0]                     rs2_o,
  output logic [31:0]                    imm_o
);
  import decode_pkg::*;

  logic [ROBID_W-1:0] rob_robid;

  fetch_de_if fetch_de ();

  fetch_queue #(.FQ_DEPTH(FQ_DEPTH)) fetch_queue_inst (
    .clk, .rst_i, .flush_i, .fetch_valid_i, .fetch_error_i, .fetch_bptaken_i,
    .fetch_addr_i, .fetch_insn_i, .fetch_bptag_i, .fetch_ready_o,
    .de(fetch_de.source)
  );

  decode decode_inst (
    .clk, .rst_i, .flush_i, .de(fetch_de.sink), .rob_full_i(rob_full_o),
    .rob_robid_i(rob_robid), .rename_stall_i, .rob_valid_o, .error_o, .ecause_o,
    .retop_o, .bptag_o, .bptaken_o, .rd_o, .addr_o, .target_o, .forward_o,
    .rename_valid_o, .rsop_o, .robid_o, .uses_rs1_o, .uses_rs2_o, .uses_imm_o,
    .uses_memory_o, .uses_pc_o, .csr_access_o, .inhibit_o, .rs1_o, .rs2_o, .imm_o
  );

  rob_tracker #(.ROB_DEPTH(ROB_DEPTH)) rob_tracker_inst (
    .clk, .rst_i, .flush_i, .retire_i, .rob_valid_i(rob_valid_o),
    .rob_full_o, .robid_o(rob_robid)
  );

endmodule

// ==== dv/tb_frontend_decode.sv ====
// tb_frontend_decode: clock, reset, directed decode tests, reference decode model, timeout
`timescale 1ns/1ps

module tb_frontend_decode;
  import decode_pkg::*;

  // about 45 decoded words at 4 cycles each plus the ROB and flush tests and wide margin
  localparam int MAX_CYCLES = 3000;

  logic clk, rst_i, flush_i, retire_i, rename_stall_i;
  logic fetch_valid_i, fetch_error_i, fetch_bptaken_i, fetch_ready_o;
  logic [31:1] fetch_addr_i;
  logic [31:0] fetch_insn_i;
  logic [BPTAG_W-1:0] fetch_bptag_i, bptag_o;
  logic rob_full_o, rob_valid_o, error_o, bptaken_o, forward_o, rename_valid_o;
  ecause_e ecause_o;
  logic [RETOP_W-1:0] retop_o;
  logic [5:0] rd_o;
  logic [31:2] addr_o, target_o;
  logic [RSOP_W-1:0] rsop_o;
  logic [ROBID_W-1:0] robid_o;
  logic uses_rs1_o, uses_rs2_o, uses_imm_o, uses_memory_o, uses_pc_o;
  logic csr_access_o, inhibit_o;
  logic [4:0] rs1_o, rs2_o;
  logic [31:0] imm_o;

  int errors = 0;
  int checked = 0;
  int cycles = 0;
  logic [31:0] seed = 32'd73;

  frontend_decode_top #(.FQ_DEPTH(4), .ROB_DEPTH(8)) frontend_decode_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  endtask

  // instruction word builders
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic fmt_e ref_fmt(input logic [31:0] w);
    if (w[1:0] != 2'b11) return FMT_INV;
    case (opcode_e'(w[6:2]))
      OP:                                 return FMT_R;
      OPIMM, LOAD, JALR, MISCMEM, SYSTEM: return FMT_I;
      STORE:                              return FMT_S;
      BRANCH:                             return FMT_B;
      LUI, AUIPC:                         return FMT_U;
      JAL:                                return FMT_J;
      default:                            return FMT_INV;
    endcase
  endfunction

  // ximm is the immediate the word was built with
  task automatic check_decode(input logic [31:0] w, input logic [31:0] pc, input logic fe,
                              input logic tk, input logic [31:0] ximm);
    fmt_e f;
    logic [2:0] f3;
    logic is_r, is_i, is_s, is_b, is_u, is_j, is_jalr, is_mem, is_csr, err, use_rd, xrs1;
    logic [31:0] t, xout;
    logic [RSOP_W-1:0] xrsop;
    ecause_e xcause;
    f = ref_fmt(w);
    f3 = w[14:12];
    is_r = (f == FMT_R);
    is_i = (f == FMT_I);
    is_s = (f == FMT_S);
    is_b = (f == FMT_B);
    is_u = (f == FMT_U);
    is_j = (f == FMT_J);
    is_jalr = (w[6:2] == JALR);
    is_mem = (w[6:2] == LOAD) || is_s;
    is_csr = (w[6:2] == SYSTEM) && (f3[1:0] != 2'b00);
    err = fe || (f == FMT_INV);
    use_rd = (is_r || is_i || is_u || is_j) && (w[11:7] != 5'd0);
    xrs1 = is_r || (is_i && !(is_csr && f3[2])) || is_s || is_b;
    xcause = !fe ? ECAUSE_IILLEGAL : (pc[1] ? ECAUSE_IALIGN : ECAUSE_IFAULT);
    t = {pc[31:2], 2'b00} + (((is_b && tk) || is_jalr) ? 32'd4 : ximm);
    xout = is_j ? 32'd4 : ximm;
    if (is_mem) xrsop = {1'b0, is_s, f3};
    else if (is_j || is_jalr || is_u) xrsop = '0;
    else if (is_b) xrsop = {2'b01, f3[2:1] == 2'b00, f3[2:1]};
    else xrsop = {is_r && w[25], (is_r || f3 == 3'b101) && w[30], f3};
    checked++;
    if (error_o !== err) report_mismatch("error_o", error_o, err);
    if (err && ecause_o !== xcause) report_mismatch("ecause_o", ecause_o, xcause);
    if (rename_valid_o !== !err) report_mismatch("rename_valid_o", rename_valid_o, !err);
    if (rsop_o !== xrsop) report_mismatch("rsop_o", rsop_o, xrsop);
    if (imm_o !== xout) report_mismatch("imm_o", imm_o, xout);
    if (rd_o !== {!use_rd, w[11:7]}) report_mismatch("rd_o", rd_o, {!use_rd, w[11:7]});
    if (rs1_o !== w[19:15]) report_mismatch("rs1_o", rs1_o, w[19:15]);
    if (rs2_o !== w[24:20]) report_mismatch("rs2_o", rs2_o, w[24:20]);
    if (addr_o !== pc[31:2]) report_mismatch("addr_o", addr_o, pc[31:2]);
    if (target_o !== t[31:2]) report_mismatch("target_o", target_o, t[31:2]);
    if (retop_o !== {is_b, f3[0], is_jalr, is_s, f3})
      report_mismatch("retop_o", retop_o, {is_b, f3[0], is_jalr, is_s, f3});
    if (uses_rs1_o !== xrs1) report_mismatch("uses_rs1_o", uses_rs1_o, xrs1);
    if (uses_rs2_o !== (is_r || is_s || is_b))
      report_mismatch("uses_rs2_o", uses_rs2_o, is_r || is_s || is_b);
    if (uses_imm_o !== !(is_r || is_b))
      report_mismatch("uses_imm_o", uses_imm_o, !(is_r || is_b));
    if (uses_memory_o !== is_mem) report_mismatch("uses_memory_o", uses_memory_o, is_mem);
    if (uses_pc_o !== (is_j || w[6:2] == AUIPC))
      report_mismatch("uses_pc_o", uses_pc_o, is_j || w[6:2] == AUIPC);
    if (forward_o !== is_jalr) report_mismatch("forward_o", forward_o, is_jalr);
    if (inhibit_o !== is_jalr) report_mismatch("inhibit_o", inhibit_o, is_jalr);
    if (csr_access_o !== is_csr) report_mismatch("csr_access_o", csr_access_o, is_csr);
    if (bptag_o !== fetch_bptag_i) report_mismatch("bptag_o", bptag_o, fetch_bptag_i);
    if (bptaken_o !== tk) report_mismatch("bptaken_o", bptaken_o, tk);
  endtask

  // called and returns on a falling edge
  task automatic push_word(input logic [31:0] w, input logic [31:0] pc, input logic fe,
                           input logic tk);
    while (!fetch_ready_o) @(negedge clk);
    fetch_valid_i = 1'b1;
    fetch_insn_i = w;
    fetch_addr_i = pc[31:1];
    fetch_error_i = fe;
    fetch_bptaken_i = tk;
    fetch_bptag_i = BPTAG_W'(lcg_next() >> 8);
    @(negedge clk);
    fetch_valid_i = 1'b0;
  endtask

  task automatic wait_rob_valid();
    while (!rob_valid_o) @(negedge clk);
  endtask

  task automatic run_one(input logic [31:0] w, input logic [31:0] pc, input logic fe,
                         input logic tk, input logic [31:0] ximm);
    push_word(w, pc, fe, tk);
    wait_rob_valid();
    check_decode(w, pc, fe, tk, ximm);
    @(negedge clk);
    retire_i = 1'b1;
    @(negedge clk);
    retire_i = 1'b0;
  endtask

  task automatic flush_pulse();
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
  endtask

  task automatic alu_tests();
    logic [31:0] r, pc;
    logic [4:0] rd;
    for (int i = 0; i < 4; i++) begin
      r = lcg_next();
      pc = lcg_next() & ~32'd3;
      // first pass writes x0
      rd = (i == 0) ? 5'd0 : r[11:7];
      run_one(enc_i(r[31:20], r[19:15], 3'd0, rd, 7'h13), pc, 1'b0, 1'b0,
              {{20{r[31]}}, r[31:20]});
      run_one(enc_i(r[31:20], r[19:15], 3'd2, rd, 7'h13), pc + 4, 1'b0, 1'b0,
              {{20{r[31]}}, r[31:20]});
      run_one(enc_i({7'h20, r[24:20]}, r[19:15], 3'd5, rd, 7'h13), pc + 8, 1'b0, 1'b0,
              {20'd0, 7'h20, r[24:20]});
      run_one(enc_r(7'h00, r[24:20], r[19:15], 3'd0, rd), pc + 12, 1'b0, 1'b0, 32'd0);
      run_one(enc_r(7'h20, r[24:20], r[19:15], 3'd0, rd), pc + 16, 1'b0, 1'b0, 32'd0);
    end
  endtask

  task automatic mem_branch_jump_tests();
    logic [31:0] r, pc;
    logic [12:0] b;
    logic [20:0] j;
    for (int i = 0; i < 2; i++) begin
      r = lcg_next();
      pc = lcg_next() & ~32'd3;
      b = {r[12:1], 1'b0};
      j = {r[20:1], 1'b0};
      run_one(enc_i(r[31:20], r[19:15], 3'd2, r[11:7], 7'h03), pc, 1'b0, 1'b0,
              {{20{r[31]}}, r[31:20]});
      run_one({r[31:25], r[24:20], r[19:15], 3'd2, r[11:7], 7'h23}, pc, 1'b0, 1'b0,
              {{20{r[31]}}, r[31:25], r[11:7]});
      for (int tk = 0; tk < 2; tk++) begin
        run_one({b[12], b[10:5], r[24:20], r[19:15], 3'd0, b[4:1], b[11], 7'h63}, pc, 1'b0,
                tk[0], {{19{b[12]}}, b});
      end
      run_one({j[20], j[10:1], j[11], j[19:12], r[11:7], 7'h6F}, pc, 1'b0, 1'b0,
              {{11{j[20]}}, j});
      run_one(enc_i(r[31:20], r[19:15], 3'd0, r[11:7], 7'h67), pc, 1'b0, 1'b0,
              {{20{r[31]}}, r[31:20]});
      run_one({r[31:12], r[11:7], 7'h37}, pc, 1'b0, 1'b0, {r[31:12], 12'd0});
      run_one({r[31:12], r[11:7], 7'h17}, pc, 1'b0, 1'b0, {r[31:12], 12'd0});
      // csrrsi reads no rs1
      run_one(enc_i(r[31:20], r[19:15], 3'd6, r[11:7], 7'h73), pc, 1'b0, 1'b0,
              {{20{r[31]}}, r[31:20]});
    end
  endtask

  task automatic error_tests();
    opcode_e rsv [3] = '{RESERVED0, RESERVED1, RESERVED2};
    logic [31:0] r;
    r = lcg_next();
    // compressed word with the OP pattern in bits 6:2
    run_one(32'h0000_0431, 32'h0000_3000, 1'b0, 1'b0, 32'd0);
    run_one({5'b00010, 2'b00, 5'd0, r[19:15], 3'd2, r[11:7], 7'h2F}, 32'h0000_3004,
            1'b0, 1'b0, 32'd0);
    foreach (rsv[k]) begin
      r = lcg_next();
      run_one({r[31:7], rsv[k], 2'b11}, 32'h0000_3008, 1'b0, 1'b0, 32'd0);
    end
    run_one(enc_i(12'h055, 5'd1, 3'd0, 5'd2, 7'h13), 32'h0000_300A, 1'b1, 1'b0, 32'h55);
    run_one(enc_i(12'h055, 5'd1, 3'd0, 5'd2, 7'h13), 32'h0000_300C, 1'b1, 1'b0, 32'h55);
  endtask

  task automatic rob_backpressure_test();
    logic [31:2] seen_addr [$];
    logic [ROBID_W-1:0] seen_id [$];
    int pushed, n;
    logic saw_full, saw_not_ready;
    pushed = 0;
    saw_full = 1'b0;
    saw_not_ready = 1'b0;
    flush_pulse();
    for (int c = 0; c < 30; c++) begin
      @(negedge clk);
      if (rob_valid_o) begin
        seen_addr.push_back(addr_o);
        seen_id.push_back(robid_o);
      end
      if (rob_full_o) begin
        saw_full = 1'b1;
        if (rename_valid_o !== 1'b0) report_mismatch("rename_valid_o", rename_valid_o, 0);
      end
      if (!fetch_ready_o) saw_not_ready = 1'b1;
      fetch_valid_i = (pushed < 13) && fetch_ready_o;
      if (fetch_valid_i) begin
        fetch_insn_i = enc_i(12'(pushed), 5'd1, 3'd0, 5'd2, 7'h13);
        fetch_addr_i = 31'((32'h4000 + 32'(pushed) * 4) >> 1);
        fetch_error_i = 1'b0;
        pushed++;
      end
    end
    if (seen_addr.size() != 8)
      report_mismatch("allocations before retire", seen_addr.size(), 8);
    if (!saw_full) $display("error: rob_full_o never rose with eight entries allocated");
    if (!saw_not_ready) $display("error: fetch_ready_o never fell with the queue full");
    if (!saw_full || !saw_not_ready) errors++;
    for (int k = 0; k < 5; k++) begin
      @(negedge clk);
      retire_i = 1'b1;
      @(negedge clk);
      retire_i = 1'b0;
      n = 0;
      repeat (5) begin
        if (rob_valid_o) begin
          seen_addr.push_back(addr_o);
          seen_id.push_back(robid_o);
          n++;
        end
        @(negedge clk);
      end
      if (n != 1) report_mismatch("rob_valid_o pulses per retire", n, 1);
    end
    if (seen_addr.size() != 13) report_mismatch("instructions allocated", seen_addr.size(), 13);
    foreach (seen_addr[k]) begin
      if (seen_addr[k] !== 30'(32'h1000 + k))
        report_mismatch("addr_o", seen_addr[k], 32'h1000 + k);
      if (seen_id[k] !== ROBID_W'(k % 8)) report_mismatch("robid_o", seen_id[k], k % 8);
    end
  endtask

  task automatic stall_flush_test();
    flush_pulse();
    push_word(enc_i(12'h123, 5'd3, 3'd0, 5'd4, 7'h13), 32'h5000, 1'b0, 1'b0);
    push_word(enc_r(7'h00, 5'd5, 5'd6, 3'd0, 5'd7), 32'h5004, 1'b0, 1'b0);
    wait_rob_valid();
    rename_stall_i = 1'b1;
    repeat (5) begin
      @(negedge clk);
      if (rob_valid_o !== 1'b0) report_mismatch("rob_valid_o", rob_valid_o, 0);
      if (addr_o !== 30'h1400) report_mismatch("addr_o", addr_o, 30'h1400);
      if (imm_o !== 32'h123) report_mismatch("imm_o", imm_o, 32'h123);
    end
    rename_stall_i = 1'b0;
    @(negedge clk);
    // held word allocated exactly once, next one follows
    if (rob_valid_o !== 1'b1) report_mismatch("rob_valid_o", rob_valid_o, 1);
    if (addr_o !== 30'h1401) report_mismatch("addr_o", addr_o, 30'h1401);
    if (robid_o !== 7'd1) report_mismatch("robid_o", robid_o, 1);
    push_word(enc_i(12'h011, 5'd1, 3'd0, 5'd1, 7'h13), 32'h6000, 1'b0, 1'b0);
    wait_rob_valid();
    rename_stall_i = 1'b1;
    push_word(enc_i(12'h022, 5'd1, 3'd0, 5'd1, 7'h13), 32'h6004, 1'b0, 1'b0);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    rename_stall_i = 1'b0;
    repeat (6) begin
      @(negedge clk);
      if (rob_valid_o !== 1'b0) report_mismatch("rob_valid_o", rob_valid_o, 0);
      if (robid_o !== 7'd0) report_mismatch("robid_o", robid_o, 0);
    end
    push_word(enc_i(12'h033, 5'd1, 3'd0, 5'd1, 7'h13), 32'h7000, 1'b0, 1'b0);
    wait_rob_valid();
    if (addr_o !== 30'h1C00) report_mismatch("addr_o", addr_o, 30'h1C00);
    if (robid_o !== 7'd0) report_mismatch("robid_o", robid_o, 0);
  endtask

  initial begin
    rst_i = 1'b1;
    flush_i = 1'b0;
    retire_i = 1'b0;
    rename_stall_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_error_i = 1'b0;
    fetch_bptaken_i = 1'b0;
    fetch_addr_i = '0;
    fetch_insn_i = '0;
    fetch_bptag_i = '0;
    repeat (8) @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    alu_tests();
    mem_branch_jump_tests();
    error_tests();
    rob_backpressure_test();
    stall_flush_test();
    $display("%0d instructions checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/decode_pkg.sv
design/fetch_de_if.sv
design/fetch_queue.sv
design/decode.sv
design/rob_tracker.sv
design/frontend_decode_top.sv
dv/tb_frontend_decode.sv

// ==== Bender.yml ====
package:
  name: frontend_decode

sources:
  - design/decode_pkg.sv
  - design/fetch_de_if.sv
  - design/fetch_queue.sv
  - design/decode.sv
  - design/rob_tracker.sv
  - design/frontend_decode_top.sv
  - target: test
    files:
      - dv/tb_frontend_decode.sv
